//--- hdl/ex_params.svh
/*
 * Execute stage parameters
 * Data width, reset PC and multiplier step width
 */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data path width
`define EX_XLEN 32

// Value of the registered PC after reset
`define EX_PC_INIT 32'h0000_0200

// Multiplier bits consumed per cycle
`define EX_MUL_STEP 8

`endif

//--- hdl/ex_pkg.sv
/*
 * Execute stage types
 * Opcode and multiplier state enums, instruction, exception
 * and data-memory request structs
 */
`default_nettype none
`include "ex_params.svh"

package ex_pkg;

  // Decoded operation delivered by decode
  typedef enum logic [4:0] {
    NOP,
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    LUI,
    LW,
    SW,
    MUL,
    BEQ,
    BNE,
    BLT,
    BGE,
    JAL,
    JALR
  } ex_op_e;

  typedef struct packed {
    logic                bubble;
    ex_op_e              op;
    logic [`EX_XLEN-1:0] imm;
  } ex_insn_t;

  typedef struct packed {
    logic misaligned_load;
    logic misaligned_store;
    logic access_fault;
  } ex_exc_t;

  // One word access on the data-memory port
  typedef struct packed {
    logic [`EX_XLEN-1:0] adr;
    logic                we;
    logic [`EX_XLEN-1:0] wdata;
  } dmem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mul_state_e;

endpackage

`default_nettype wire

//--- hdl/ex_alu.sv
/*
 * Integer ALU
 * Add, subtract, logic, shifts, compares and LUI,
 * result registered one cycle after capture
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_alu (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 ex_stall_i,
  input  wire ex_pkg::ex_insn_t     id_insn_i,
  input  wire logic [`EX_XLEN-1:0]  opa_i,
  input  wire logic [`EX_XLEN-1:0]  opb_i,
  output logic                      alu_bubble_o,
  output logic [`EX_XLEN-1:0]       alu_r_o
);

  import ex_pkg::*;

  localparam int XLEN = `EX_XLEN;

  logic            is_alu;
  logic [4:0]      shamt;
  logic [XLEN-1:0] result;

  // RV32 shifts only look at the low 5 bits
  assign shamt = opb_i[4:0];

  always_comb
  begin
    is_alu = 1'b1;
    result = '0;
    case (id_insn_i.op)
      ADD:     result = opa_i + opb_i;
      SUB:     result = opa_i - opb_i;
      AND:     result = opa_i & opb_i;
      OR:      result = opa_i | opb_i;
      XOR:     result = opa_i ^ opb_i;
      SLL:     result = opa_i << shamt;
      SRL:     result = opa_i >> shamt;
      SRA:     result = $signed(opa_i) >>> shamt;
      SLT:     result = {{(XLEN-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
      SLTU:    result = {{(XLEN-1){1'b0}}, opa_i < opb_i};
      // Decode supplies the already shifted upper immediate
      LUI:     result = id_insn_i.imm;
      default: is_alu = 1'b0;
    endcase
    if (id_insn_i.bubble)
    begin
      is_alu = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      alu_bubble_o <= 1'b1;
      alu_r_o      <= '0;
    end
    else if (!ex_stall_i)
    begin
      alu_bubble_o <= ~is_alu;
      alu_r_o      <= result;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ex_bu.sv
/*
 * Branch unit
 * Resolves conditional branches and jumps under static
 * not-taken prediction, raises a one-cycle flush with target
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_bu (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 ex_stall_i,
  input  wire logic [`EX_XLEN-1:0]  id_pc_i,
  input  wire ex_pkg::ex_insn_t     id_insn_i,
  input  wire logic [`EX_XLEN-1:0]  opa_i,
  input  wire logic [`EX_XLEN-1:0]  opb_i,
  output logic                      bu_bubble_o,
  output logic [`EX_XLEN-1:0]       bu_r_o,
  output logic                      bu_flush_o,
  output logic [`EX_XLEN-1:0]       bu_nxt_pc_o
);

  import ex_pkg::*;

  localparam int XLEN = `EX_XLEN;

  logic            taken;
  logic            is_jump;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] link;

  assign link     = id_pc_i + XLEN'(4);
  assign jalr_sum = opa_i + id_insn_i.imm;

  always_comb
  begin
    taken   = 1'b0;
    is_jump = 1'b0;
    target  = id_pc_i + id_insn_i.imm;
    case (id_insn_i.op)
      BEQ:  taken = (opa_i == opb_i);
      BNE:  taken = (opa_i != opb_i);
      BLT:  taken = ($signed(opa_i) <  $signed(opb_i));
      BGE:  taken = ($signed(opa_i) >= $signed(opb_i));
      JAL:  is_jump = 1'b1;
      JALR:
      begin
        is_jump = 1'b1;
        target  = {jalr_sum[XLEN-1:1], 1'b0};
      end
      default: ;
    endcase
    if (id_insn_i.bubble)
    begin
      taken   = 1'b0;
      is_jump = 1'b0;
    end
  end

  // Flush is recomputed every cycle so it never lasts past one clock
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bu_flush_o  <= 1'b0;
      bu_bubble_o <= 1'b1;
      bu_r_o      <= '0;
      bu_nxt_pc_o <= `EX_PC_INIT;
    end
    else
    begin
      bu_flush_o <= ~ex_stall_i & (taken | is_jump);
      if (!ex_stall_i)
      begin
        // Only jumps write a link value
        bu_bubble_o <= ~is_jump;
        bu_r_o      <= link;
        bu_nxt_pc_o <= target;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/ex_lsu.sv
/*
 * Load/store unit
 * Word loads and stores over a request/ack data-memory port,
 * with alignment check, access fault capture and stage stall
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_lsu (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 ex_stall_i,
  output logic                      lsu_stall_o,
  input  wire ex_pkg::ex_insn_t     id_insn_i,
  input  wire logic [`EX_XLEN-1:0]  opa_i,
  input  wire logic [`EX_XLEN-1:0]  opb_i,
  output logic                      lsu_bubble_o,
  output logic [`EX_XLEN-1:0]       lsu_r_o,
  output ex_pkg::ex_exc_t           lsu_exc_o,
  output logic                      dmem_req_o,
  output ex_pkg::dmem_req_t         dmem_o,
  input  wire logic [`EX_XLEN-1:0]  dmem_rdata_i,
  input  wire logic                 dmem_ack_i,
  input  wire logic                 dmem_err_i
);

  import ex_pkg::*;

  localparam int XLEN = `EX_XLEN;

  logic [XLEN-1:0] adr;
  logic            is_load;
  logic            is_store;
  logic            misaligned;
  logic            issue;
  logic            req_q;

  assign adr        = opa_i + id_insn_i.imm;
  assign is_load    = ~id_insn_i.bubble & (id_insn_i.op == LW);
  assign is_store   = ~id_insn_i.bubble & (id_insn_i.op == SW);
  assign misaligned = |adr[1:0];
  assign issue      = ~ex_stall_i & (is_load | is_store) & ~misaligned;

  // Stall covers the whole access, ack cycle included
  assign dmem_req_o  = req_q;
  assign lsu_stall_o = req_q;

  //////////////////////////////////////////////////
  // Control, result and exceptions
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_q        <= 1'b0;
      lsu_bubble_o <= 1'b1;
      lsu_r_o      <= '0;
      lsu_exc_o    <= '0;
    end
    else if (req_q)
    begin
      // Ack is taken even under a memory stage stall
      if (dmem_ack_i)
      begin
        req_q                  <= 1'b0;
        lsu_exc_o.access_fault <= dmem_err_i;
        if (!dmem_o.we)
        begin
          lsu_r_o <= dmem_rdata_i;
        end
      end
    end
    else if (!ex_stall_i)
    begin
      req_q        <= issue;
      lsu_bubble_o <= ~(is_load | is_store);
      lsu_r_o      <= '0;
      lsu_exc_o    <= '{misaligned_load:  is_load & misaligned,
                        misaligned_store: is_store & misaligned,
                        access_fault:     1'b0};
    end
  end

  //////////////////////////////////////////////////
  // Request payload, held until the ack
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      dmem_o <= '{adr: adr, we: is_store, wdata: opb_i};
    end
  end

endmodule

`default_nettype wire

//--- hdl/ex_mul.sv
/*
 * Iterative multiplier
 * Shift-add over several multiplier bits per cycle, stalls the
 * stage while busy, returns the low word of the product
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_mul (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 mem_stall_i,
  input  wire logic                 ex_stall_i,
  output logic                      mul_stall_o,
  input  wire ex_pkg::ex_insn_t     id_insn_i,
  input  wire logic [`EX_XLEN-1:0]  opa_i,
  input  wire logic [`EX_XLEN-1:0]  opb_i,
  output logic                      mul_bubble_o,
  output logic [`EX_XLEN-1:0]       mul_r_o
);

  import ex_pkg::*;

  localparam int XLEN  = `EX_XLEN;
  localparam int STEP  = `EX_MUL_STEP;
  localparam int STEPS = XLEN / STEP;
  localparam int CNT_W = $clog2(STEPS);

  mul_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]  mcand_q;
  logic [XLEN-1:0]  mplier_q;
  logic             start;
  logic             advance;

  // Partial product of the multiplicand with one slice of multiplier bits
  function automatic logic [XLEN-1:0] slice_sum(input logic [XLEN-1:0] mcand,
                                                input logic [STEP-1:0] bits);
    logic [XLEN-1:0] sum;
    sum = '0;
    for (int i = 0; i < STEP; i++)
    begin
      if (bits[i])
      begin
        sum = sum + (mcand << i);
      end
    end
    return sum;
  endfunction

  assign start        = ~ex_stall_i & ~id_insn_i.bubble & (id_insn_i.op == MUL);
  assign advance      = (state_q == BUSY) & ~mem_stall_i;
  assign mul_stall_o  = (state_q == BUSY);
  assign mul_bubble_o = (state_q == IDLE);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
      mul_r_o <= '0;
    end
    else if (advance)
    begin
      cnt_q   <= cnt_q + 1'b1;
      mul_r_o <= mul_r_o + slice_sum(mcand_q, mplier_q[STEP-1:0]);
      if (cnt_q == CNT_W'(STEPS - 1))
      begin
        state_q <= DONE;
      end
    end
    else if (!ex_stall_i)
    begin
      state_q <= start ? BUSY : IDLE;
      cnt_q   <= '0;
      if (start)
      begin
        mul_r_o <= '0;
      end
    end
  end

  // Operand shifters walk one slice per step
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      mcand_q  <= opa_i;
      mplier_q <= opb_i;
    end
    else if (advance)
    begin
      mcand_q  <= mcand_q << STEP;
      mplier_q <= mplier_q >> STEP;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ex_stage.sv
/*
 * Execute stage top
 * Operand bypass, PC and instruction registers, ALU, branch,
 * load/store and multiply units, result select and stall
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_stage (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // From decode and register file
  input  wire logic [`EX_XLEN-1:0]  id_pc_i,
  input  wire ex_pkg::ex_insn_t     id_insn_i,
  input  wire logic [`EX_XLEN-1:0]  id_opa_i,
  input  wire logic [`EX_XLEN-1:0]  id_opb_i,
  input  wire logic [`EX_XLEN-1:0]  rf_srcv1_i,
  input  wire logic [`EX_XLEN-1:0]  rf_srcv2_i,
  input  wire logic                 id_userf_opa_i,
  input  wire logic                 id_userf_opb_i,
  input  wire logic                 id_bypex_opa_i,
  input  wire logic                 id_bypex_opb_i,
  // To memory stage
  output logic [`EX_XLEN-1:0]       ex_pc_o,
  output ex_pkg::ex_insn_t          ex_insn_o,
  output logic [`EX_XLEN-1:0]       ex_r_o,
  output ex_pkg::ex_exc_t           ex_exc_o,
  // Redirect and stall
  output logic                      bu_flush_o,
  output logic [`EX_XLEN-1:0]       bu_nxt_pc_o,
  output logic                      ex_stall_o,
  input  wire logic                 mem_stall_i,
  // Data memory
  output logic                      dmem_req_o,
  output ex_pkg::dmem_req_t         dmem_o,
  input  wire logic [`EX_XLEN-1:0]  dmem_rdata_i,
  input  wire logic                 dmem_ack_i,
  input  wire logic                 dmem_err_i
);

  import ex_pkg::*;

  localparam int XLEN = `EX_XLEN;

  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] alu_r, bu_r, lsu_r, mul_r;
  logic            alu_bubble, bu_bubble, lsu_bubble, mul_bubble;
  logic            lsu_stall, mul_stall;
  ex_op_e          op_q;
  logic [XLEN-1:0] imm_q;

  // Previous result first, then register file, then decode value
  function automatic logic [XLEN-1:0] bypass(input logic            bypex,
                                             input logic            userf,
                                             input logic [XLEN-1:0] ex_r,
                                             input logic [XLEN-1:0] rf,
                                             input logic [XLEN-1:0] id);
    return bypex ? ex_r : (userf ? rf : id);
  endfunction

  assign opa = bypass(id_bypex_opa_i, id_userf_opa_i, ex_r_o, rf_srcv1_i, id_opa_i);
  assign opb = bypass(id_bypex_opb_i, id_userf_opb_i, ex_r_o, rf_srcv2_i, id_opb_i);

  //////////////////////////////////////////////////
  // PC and instruction
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ex_pc_o <= `EX_PC_INIT;
      op_q    <= NOP;
      imm_q   <= '0;
    end
    else if (!ex_stall_o)
    begin
      ex_pc_o <= id_pc_i;
      op_q    <= id_insn_i.op;
      imm_q   <= id_insn_i.imm;
    end
  end

  ex_alu u_alu (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .ex_stall_i   ( ex_stall_o ),
    .id_insn_i    ( id_insn_i  ),
    .opa_i        ( opa        ),
    .opb_i        ( opb        ),
    .alu_bubble_o ( alu_bubble ),
    .alu_r_o      ( alu_r      )
  );

  ex_bu u_bu (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ex_stall_i  ( ex_stall_o  ),
    .id_pc_i     ( id_pc_i     ),
    .id_insn_i   ( id_insn_i   ),
    .opa_i       ( opa         ),
    .opb_i       ( opb         ),
    .bu_bubble_o ( bu_bubble   ),
    .bu_r_o      ( bu_r        ),
    .bu_flush_o  ( bu_flush_o  ),
    .bu_nxt_pc_o ( bu_nxt_pc_o )
  );

  ex_lsu u_lsu (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ex_stall_i   ( ex_stall_o   ),
    .lsu_stall_o  ( lsu_stall    ),
    .id_insn_i    ( id_insn_i    ),
    .opa_i        ( opa          ),
    .opb_i        ( opb          ),
    .lsu_bubble_o ( lsu_bubble   ),
    .lsu_r_o      ( lsu_r        ),
    .lsu_exc_o    ( ex_exc_o     ),
    .dmem_req_o   ( dmem_req_o   ),
    .dmem_o       ( dmem_o       ),
    .dmem_rdata_i ( dmem_rdata_i ),
    .dmem_ack_i   ( dmem_ack_i   ),
    .dmem_err_i   ( dmem_err_i   )
  );

  ex_mul u_mul (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .mem_stall_i  ( mem_stall_i ),
    .ex_stall_i   ( ex_stall_o  ),
    .mul_stall_o  ( mul_stall   ),
    .id_insn_i    ( id_insn_i   ),
    .opa_i        ( opa         ),
    .opb_i        ( opb         ),
    .mul_bubble_o ( mul_bubble  ),
    .mul_r_o      ( mul_r       )
  );

  //////////////////////////////////////////////////
  // Result select and stall
  //////////////////////////////////////////////////
  always_comb
  begin
    if (!lsu_bubble)
    begin
      ex_r_o = lsu_r;
    end
    else if (!mul_bubble)
    begin
      ex_r_o = mul_r;
    end
    else if (!bu_bubble)
    begin
      ex_r_o = bu_r;
    end
    else
    begin
      ex_r_o = alu_r;
    end
  end

  assign ex_insn_o = '{bubble: alu_bubble & bu_bubble & lsu_bubble & mul_bubble,
                       op:     op_q,
                       imm:    imm_q};

  assign ex_stall_o = mem_stall_i | lsu_stall | mul_stall;

endmodule

`default_nettype wire

//--- tests/ex_stage_assertions.sv
/*
 * Execute stage port assertions
 * Data-memory request hold, flush pulse width, output hold under stall
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_stage_assertions (
  input wire logic                 clk_i,
  input wire logic                 rst_ni,
  input wire logic                 dmem_req_o,
  input wire ex_pkg::dmem_req_t    dmem_o,
  input wire logic                 dmem_ack_i,
  input wire logic                 bu_flush_o,
  input wire logic                 mem_stall_i,
  input wire logic [`EX_XLEN-1:0]  ex_pc_o,
  input wire ex_pkg::ex_insn_t     ex_insn_o,
  input wire logic [`EX_XLEN-1:0]  ex_r_o,
  input wire ex_pkg::ex_exc_t      ex_exc_o
);

  // Number of failed assertions
  int fail_count = 0;

  // Request stays up with a stable payload until acknowledged
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_o && !dmem_ack_i |=> dmem_req_o && $stable(dmem_o))
    else
    begin
      $error("dmem request dropped or changed before ack");
      fail_count++;
    end

  // A redirect flushes for exactly one cycle
  flush_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu_flush_o |=> !bu_flush_o)
    else
    begin
      $error("bu_flush_o held for more than one cycle");
      fail_count++;
    end

  // Memory stage stall with no access outstanding freezes all results
  out_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_stall_i && !dmem_req_o |=>
      $stable(ex_pc_o) && $stable(ex_insn_o) && $stable(ex_r_o) && $stable(ex_exc_o))
    else
    begin
      $error("stage outputs changed under mem_stall_i");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tests/ex_stage_tb.sv
/*
 * Execute stage testbench
 * Random instruction stream with bypass, data-memory responder,
 * reference model, memory stage stall pulses and watchdog
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_stage_tb;

  import ex_pkg::*;

  localparam int XLEN        = `EX_XLEN;
  localparam int NUM_INSN    = 400;
  localparam int MEM_WORDS   = 256;
  localparam int CLK_HALF    = 20;
  localparam int RST_CYCLES  = 16;
  localparam int WATCHDOG_NS = (NUM_INSN * 10 + RST_CYCLES) * 2 * CLK_HALF;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic [XLEN-1:0] id_pc_i, id_opa_i, id_opb_i, rf_srcv1_i, rf_srcv2_i;
  ex_insn_t        id_insn_i;
  logic            id_userf_opa_i, id_userf_opb_i, id_bypex_opa_i, id_bypex_opb_i;
  logic [XLEN-1:0] ex_pc_o, ex_r_o, bu_nxt_pc_o, dmem_rdata_i;
  ex_insn_t        ex_insn_o;
  ex_exc_t         ex_exc_o;
  logic            bu_flush_o, ex_stall_o, mem_stall_i;
  logic            dmem_req_o, dmem_ack_i, dmem_err_i;
  dmem_req_t       dmem_o;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [XLEN-1:0] model_mem [MEM_WORDS];
  logic [XLEN-1:0] last_r;
  logic            kill_next;
  int              errors = 0;
  int              checks = 0;

  ex_stage u_dut (.*);

  bind ex_stage ex_stage_assertions u_assertions (.*);

  always #CLK_HALF clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_insn(input ex_insn_t got, input ex_insn_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: ex_insn_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_exc(input ex_exc_t got, input ex_exc_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: ex_exc_o got %b expected %b", $time, got, exp);
    end
  endtask

  // Fill value mixes every address bit
  function automatic logic [XLEN-1:0] fill_word(input int idx);
    return (32'(idx) * 32'h0100_0193) ^ 32'hc3a5_0f1e;
  endfunction

  //////////////////////////////////////////////////
  // Data-memory responder
  //////////////////////////////////////////////////
  initial
  begin
    dmem_req_t req;
    int        lat;
    logic      in_range;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (dmem_req_o)
      begin
        lat = $urandom_range(3, 0);
        repeat (lat)
        begin
          @(posedge clk_i);
          #1;
        end
        req          = dmem_o;
        in_range     = req.adr < 32'(MEM_WORDS * 4);
        dmem_ack_i   = 1'b1;
        dmem_err_i   = ~in_range;
        dmem_rdata_i = (in_range && !req.we) ? mem[req.adr[9:2]] : '0;
        if (in_range && req.we)
        begin
          mem[req.adr[9:2]] = req.wdata;
        end
        @(posedge clk_i);
        #1;
        dmem_ack_i   = 1'b0;
        dmem_err_i   = 1'b0;
        dmem_rdata_i = '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // One instruction through the stage
  //////////////////////////////////////////////////
  task automatic run_one();
    ex_op_e          op;
    logic [XLEN-1:0] a, b, imm, pc, tgt, exp_r, exp_pc;
    logic [XLEN-1:0] snap_r, snap_pc;
    ex_insn_t        snap_insn;
    ex_exc_t         snap_exc, exp_exc;
    logic            taken, exp_bubble, in_range;
    int              stall_cycles;
    op  = ex_op_e'($urandom_range(20, 0));
    pc  = $urandom & 32'hffff_fffc;
    imm = $urandom;
    // Decode turns the slot behind a redirect into a NOP
    if (kill_next)
    begin
      op = NOP;
    end
    id_opa_i       = $urandom;
    id_opb_i       = $urandom;
    rf_srcv1_i     = $urandom;
    rf_srcv2_i     = $urandom;
    id_bypex_opa_i = $urandom_range(1, 0);
    id_bypex_opb_i = $urandom_range(1, 0);
    id_userf_opa_i = $urandom_range(1, 0);
    id_userf_opb_i = $urandom_range(1, 0);
    tgt = 32'($urandom_range(MEM_WORDS - 1, 0)) << 2;
    if (op == LW || op == SW)
    begin
      // Address from decode base plus immediate
      id_bypex_opa_i = 1'b0;
      id_userf_opa_i = 1'b0;
      case ($urandom_range(7, 0))
        0:       tgt = tgt + 32'($urandom_range(3, 1));
        1:       tgt = tgt + 32'h0000_1000;
        default: ;
      endcase
      imm = tgt - id_opa_i;
    end
    if ($urandom_range(1, 0) == 1)
    begin
      // Equal operands so branches also go the other way
      id_opb_i       = id_opa_i;
      rf_srcv2_i     = rf_srcv1_i;
      id_bypex_opb_i = id_bypex_opa_i;
      id_userf_opb_i = id_userf_opa_i;
    end
    a = id_bypex_opa_i ? last_r : (id_userf_opa_i ? rf_srcv1_i : id_opa_i);
    b = id_bypex_opb_i ? last_r : (id_userf_opb_i ? rf_srcv2_i : id_opb_i);

    // Reference model
    exp_r    = '0;
    exp_exc  = '0;
    exp_pc   = pc + imm;
    taken    = 1'b0;
    in_range = tgt < 32'(MEM_WORDS * 4);
    case (op)
      ADD:  exp_r = a + b;
      SUB:  exp_r = a - b;
      AND:  exp_r = a & b;
      OR:   exp_r = a | b;
      XOR:  exp_r = a ^ b;
      SLL:  exp_r = a << b[4:0];
      SRL:  exp_r = a >> b[4:0];
      SRA:  exp_r = 32'($signed(a) >>> b[4:0]);
      SLT:  exp_r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU: exp_r = (a < b) ? 32'd1 : 32'd0;
      LUI:  exp_r = imm;
      MUL:  exp_r = a * b;
      BEQ:  taken = (a == b);
      BNE:  taken = (a != b);
      BLT:  taken = ($signed(a) < $signed(b));
      BGE:  taken = ($signed(a) >= $signed(b));
      JAL:
      begin
        taken = 1'b1;
        exp_r = pc + 32'd4;
      end
      JALR:
      begin
        taken  = 1'b1;
        exp_r  = pc + 32'd4;
        exp_pc = (a + imm) & 32'hffff_fffe;
      end
      LW:
      begin
        exp_exc.misaligned_load = |tgt[1:0];
        exp_exc.access_fault    = ~|tgt[1:0] & ~in_range;
        if (~|tgt[1:0] && in_range)
        begin
          exp_r = model_mem[tgt[9:2]];
        end
      end
      SW:
      begin
        exp_exc.misaligned_store = |tgt[1:0];
        exp_exc.access_fault     = ~|tgt[1:0] & ~in_range;
        if (~|tgt[1:0] && in_range)
        begin
          model_mem[tgt[9:2]] = b;
        end
      end
      default: ;
    endcase
    exp_bubble = op inside {NOP, BEQ, BNE, BLT, BGE};

    id_pc_i   = pc;
    id_insn_i = '{bubble: 1'b0, op: op, imm: imm};

    // Occasional memory stage stall before capture
    if ($urandom_range(3, 0) == 0)
    begin
      mem_stall_i = 1'b1;
      snap_r      = ex_r_o;
      snap_pc     = ex_pc_o;
      snap_insn   = ex_insn_o;
      snap_exc    = ex_exc_o;
      repeat ($urandom_range(3, 1))
      begin
        @(posedge clk_i);
        #1;
      end
      check_word("ex_r_o under stall", ex_r_o, snap_r);
      check_word("ex_pc_o under stall", ex_pc_o, snap_pc);
      check_insn(ex_insn_o, snap_insn);
      check_exc(ex_exc_o, snap_exc);
      mem_stall_i = 1'b0;
    end

    @(posedge clk_i);
    #1;
    stall_cycles = 0;
    while (ex_stall_o)
    begin
      stall_cycles++;
      @(posedge clk_i);
      #1;
    end

    if (op == MUL)
    begin
      check_word("mul stall cycles", 32'(stall_cycles), 32'd4);
    end
    else if (!(op inside {LW, SW}) || |tgt[1:0])
    begin
      // No memory request and no multiply, so no stall at all
      check_word("stall cycles", 32'(stall_cycles), 32'd0);
    end
    check_word("ex_pc_o", ex_pc_o, pc);
    check_insn(ex_insn_o, '{bubble: exp_bubble, op: op, imm: imm});
    check_word("ex_r_o", ex_r_o, exp_r);
    check_exc(ex_exc_o, exp_exc);
    check_word("bu_flush_o", 32'(bu_flush_o), 32'(taken));
    if (taken)
    begin
      check_word("bu_nxt_pc_o", bu_nxt_pc_o, exp_pc);
    end
    last_r    = exp_r;
    kill_next = taken;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    void'($urandom(32'h887d));
    rst_ni         = 1'b0;
    id_pc_i        = '0;
    id_insn_i      = '{bubble: 1'b1, op: NOP, imm: '0};
    id_opa_i       = '0;
    id_opb_i       = '0;
    rf_srcv1_i     = '0;
    rf_srcv2_i     = '0;
    id_userf_opa_i = 1'b0;
    id_userf_opb_i = 1'b0;
    id_bypex_opa_i = 1'b0;
    id_bypex_opb_i = 1'b0;
    mem_stall_i    = 1'b0;
    dmem_rdata_i   = '0;
    dmem_ack_i     = 1'b0;
    dmem_err_i     = 1'b0;
    last_r         = '0;
    kill_next      = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i]       = fill_word(i);
      model_mem[i] = fill_word(i);
    end

    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    check_word("ex_pc_o at reset", ex_pc_o, `EX_PC_INIT);
    check_word("bubble at reset", 32'(ex_insn_o.bubble), 32'd1);
    check_word("bu_flush_o at reset", 32'(bu_flush_o), 32'd0);
    check_word("dmem_req_o at reset", 32'(dmem_req_o), 32'd0);
    check_word("ex_stall_o at reset", 32'(ex_stall_o), 32'd0);
    check_exc(ex_exc_o, '0);
    rst_ni = 1'b1;

    for (int n = 0; n < NUM_INSN; n++)
    begin
      run_one();
    end

    errors += u_dut.u_assertions.fail_count;
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the stage did not finish", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_bu.sv
hdl/ex_lsu.sv
hdl/ex_mul.sv
hdl/ex_stage.sv
tests/ex_stage_assertions.sv
tests/ex_stage_tb.sv

//--- Makefile
# Verilator simulation of the execute stage

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
